/* src/adam_bus_pkg.sv */
package adam_bus_pkg;

    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

    // memory view: region, word index, byte offset
    typedef struct packed {
        logic        region;
        logic [12:0] word;
        logic [1:0]  offset;
    } mem_addr_t;

    // configuration view: region, unused, register index, byte offset
    typedef struct packed {
        logic        region;
        logic [10:0] rsvd;
        logic [1:0]  reg_idx;
        logic [1:0]  offset;
    } cfg_addr_t;

    typedef union packed {
        addr_t     raw;
        mem_addr_t mem;
        cfg_addr_t cfg;
    } bus_addr_u;

endpackage

/* src/adam_map_pkg.sv */
package adam_map_pkg;

    // region bit of the byte address
    localparam logic REGION_MEM = 1'b0;
    localparam logic REGION_CFG = 1'b1;

    // configuration register indices
    localparam logic [1:0] REG_CTRL      = 2'd0;
    localparam logic [1:0] REG_BOOT_ADDR = 2'd1;
    localparam logic [1:0] REG_IRQ       = 2'd2;

    // CTRL bits
    localparam int CTRL_MEM_RST_BIT   = 0;
    localparam int CTRL_MEM_PAUSE_BIT = 1;

    // IRQ bits
    localparam int IRQ_CPU_BIT = 0;

endpackage

/* src/adam_bus_if.sv */
interface adam_bus_if;

    logic                  req;
    logic                  gnt;
    adam_bus_pkg::addr_t   addr;
    logic                  we;
    adam_bus_pkg::strb_t   be;
    adam_bus_pkg::data_t   wdata;
    logic                  rvalid;
    adam_bus_pkg::data_t   rdata;

    modport master (
        output req, addr, we, be, wdata,
        input  gnt, rvalid, rdata
    );

    modport slave (
        input  req, addr, we, be, wdata,
        output gnt, rvalid, rdata
    );

endinterface

/* src/adam_arbiter.sv */
module adam_arbiter (
    input logic clk_i,
    input logic rst_i,

    adam_bus_if.slave lp_bus,
    adam_bus_if.slave hs_bus,

    adam_bus_if.master sys_bus
);

    // 0 selects lp, 1 selects hs
    logic sel;
    logic last_q;
    logic xfer;

    adam_bus_pkg::bus_addr_u sel_addr;

    // on contention the port that lost last time wins
    always_comb begin
        if (lp_bus.req && hs_bus.req) begin
            sel = ~last_q;
        end else if (hs_bus.req) begin
            sel = 1'b1;
        end else begin
            sel = 1'b0;
        end
    end

    always_comb begin
        sel_addr.raw = sel ? hs_bus.addr : lp_bus.addr;
    end

    assign sys_bus.req   = lp_bus.req || hs_bus.req;
    assign sys_bus.addr  = sel_addr.raw;
    assign sys_bus.we    = sel ? hs_bus.we : lp_bus.we;
    assign sys_bus.be    = sel ? hs_bus.be : lp_bus.be;
    assign sys_bus.wdata = sel ? hs_bus.wdata : lp_bus.wdata;

    assign lp_bus.gnt = sys_bus.gnt && !sel;
    assign hs_bus.gnt = sys_bus.gnt && sel;

    assign xfer = sys_bus.req && sys_bus.gnt;

    // winner of the last transfer, which is also the owner of the
    // response that arrives one cycle after it
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // lp goes first after reset
            last_q <= 1'b1;
        end else if (xfer) begin
            last_q <= sel;
        end
    end

    assign lp_bus.rvalid = sys_bus.rvalid && !last_q;
    assign hs_bus.rvalid = sys_bus.rvalid && last_q;

    // data is only meaningful alongside rvalid
    assign lp_bus.rdata = sys_bus.rdata;
    assign hs_bus.rdata = sys_bus.rdata;

endmodule

/* src/adam_decoder.sv */
module adam_decoder (
    input logic clk_i,
    input logic rst_i,

    adam_bus_if.slave sys_bus,

    adam_bus_if.master mem_bus,
    adam_bus_if.master cfg_bus
);

    adam_bus_pkg::bus_addr_u addr_u;

    logic region;
    logic region_q;
    logic xfer;

    assign addr_u.raw = sys_bus.addr;
    assign region     = addr_u.mem.region;

    // request fields go to both targets, req only to the selected one
    assign mem_bus.req   = sys_bus.req && (region == adam_map_pkg::REGION_MEM);
    assign mem_bus.addr  = sys_bus.addr;
    assign mem_bus.we    = sys_bus.we;
    assign mem_bus.be    = sys_bus.be;
    assign mem_bus.wdata = sys_bus.wdata;

    assign cfg_bus.req   = sys_bus.req && (region == adam_map_pkg::REGION_CFG);
    assign cfg_bus.addr  = sys_bus.addr;
    assign cfg_bus.we    = sys_bus.we;
    assign cfg_bus.be    = sys_bus.be;
    assign cfg_bus.wdata = sys_bus.wdata;

    assign sys_bus.gnt = (region == adam_map_pkg::REGION_CFG) ? cfg_bus.gnt : mem_bus.gnt;

    assign xfer = sys_bus.req && sys_bus.gnt;

    // remember where the transfer went so the response can be picked
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            region_q <= adam_map_pkg::REGION_MEM;
        end else if (xfer) begin
            region_q <= region;
        end
    end

    always_comb begin
        if (region_q == adam_map_pkg::REGION_CFG) begin
            sys_bus.rvalid = cfg_bus.rvalid;
            sys_bus.rdata  = cfg_bus.rdata;
        end else begin
            sys_bus.rvalid = mem_bus.rvalid;
            sys_bus.rdata  = mem_bus.rdata;
        end
    end

endmodule

/* src/adam_mem.sv */
module adam_mem #(
    parameter int MEM_WORDS = 1024
) (
    input logic clk_i,
    input logic rst_i,

    adam_bus_if.slave bus,

    input logic mem_rst_i,
    input logic mem_pause_i
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    adam_bus_pkg::bus_addr_u addr_u;

    logic             grant;
    logic [IDX_W-1:0] word_idx;
    logic             rvalid_q;

    adam_bus_pkg::data_t rdata_q;
    adam_bus_pkg::data_t ram [MEM_WORDS];

    assign addr_u.raw = bus.addr;

    // word index wraps around the RAM depth
    assign word_idx = IDX_W'(32'(addr_u.mem.word) % MEM_WORDS);

    // stalled while held in reset or paused
    assign grant   = bus.req && !mem_rst_i && !mem_pause_i;
    assign bus.gnt = grant;

    always_ff @(posedge clk_i) begin
        if (rst_i || mem_rst_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= grant;
        end
    end

    // byte-enabled RAM, contents kept across mem_rst_i
    always_ff @(posedge clk_i) begin
        if (grant) begin
            if (bus.we) begin
                for (int b = 0; b < adam_bus_pkg::STRB_WIDTH; b++) begin
                    if (bus.be[b]) begin
                        ram[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
                rdata_q <= '0;
            end else begin
                rdata_q <= ram[word_idx];
            end
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

endmodule

/* src/adam_syscfg.sv */
module adam_syscfg #(
    parameter adam_bus_pkg::addr_t BOOT_ADDR_RESET = 16'h0100
) (
    input logic clk_i,
    input logic rst_i,

    adam_bus_if.slave bus,

    output logic                mem_rst_o,
    output logic                mem_pause_o,
    output logic                cpu_irq_o,
    output adam_bus_pkg::addr_t cpu_boot_addr_o
);

    adam_bus_pkg::bus_addr_u addr_u;
    adam_bus_pkg::data_t     rd_word;
    adam_bus_pkg::data_t     rdata_q;

    logic [1:0]          ctrl_q;
    adam_bus_pkg::addr_t boot_q;
    logic                irq_q;
    logic                rvalid_q;
    logic                wr_en;

    assign addr_u.raw = bus.addr;

    // never stalls
    assign bus.gnt = bus.req;
    assign wr_en   = bus.req && bus.we;

    // register writes, byte 0 holds all control bits
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_q <= '0;
            boot_q <= BOOT_ADDR_RESET;
            irq_q  <= 1'b0;
        end else if (wr_en) begin
            case (addr_u.cfg.reg_idx)
                adam_map_pkg::REG_CTRL: begin
                    if (bus.be[0]) begin
                        ctrl_q[adam_map_pkg::CTRL_MEM_RST_BIT] <=
                            bus.wdata[adam_map_pkg::CTRL_MEM_RST_BIT];
                        ctrl_q[adam_map_pkg::CTRL_MEM_PAUSE_BIT] <=
                            bus.wdata[adam_map_pkg::CTRL_MEM_PAUSE_BIT];
                    end
                end
                adam_map_pkg::REG_BOOT_ADDR: begin
                    for (int b = 0; b < adam_bus_pkg::ADDR_WIDTH / 8; b++) begin
                        if (bus.be[b]) begin
                            boot_q[8*b +: 8] <= bus.wdata[8*b +: 8];
                        end
                    end
                end
                adam_map_pkg::REG_IRQ: begin
                    if (bus.be[0]) begin
                        irq_q <= bus.wdata[adam_map_pkg::IRQ_CPU_BIT];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // read mux, index 3 reads as zero
    always_comb begin
        rd_word = '0;
        case (addr_u.cfg.reg_idx)
            adam_map_pkg::REG_CTRL:      rd_word = adam_bus_pkg::data_t'(ctrl_q);
            adam_map_pkg::REG_BOOT_ADDR: rd_word = adam_bus_pkg::data_t'(boot_q);
            adam_map_pkg::REG_IRQ:       rd_word[adam_map_pkg::IRQ_CPU_BIT] = irq_q;
            default:                     rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus.req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus.req) begin
            rdata_q <= bus.we ? '0 : rd_word;
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

    assign mem_rst_o       = ctrl_q[adam_map_pkg::CTRL_MEM_RST_BIT];
    assign mem_pause_o     = ctrl_q[adam_map_pkg::CTRL_MEM_PAUSE_BIT];
    assign cpu_irq_o       = irq_q;
    assign cpu_boot_addr_o = boot_q;

endmodule

/* src/adam_mini.sv */
module adam_mini #(
    parameter int                  MEM_WORDS       = 1024,
    parameter adam_bus_pkg::addr_t BOOT_ADDR_RESET = 16'h0100
) (
    input logic clk_i,
    input logic rst_i,

    // low-power requester
    input  logic                lp_req_i,
    input  logic                lp_we_i,
    input  adam_bus_pkg::addr_t lp_addr_i,
    input  adam_bus_pkg::strb_t lp_be_i,
    input  adam_bus_pkg::data_t lp_wdata_i,
    output logic                lp_gnt_o,
    output logic                lp_rvalid_o,
    output adam_bus_pkg::data_t lp_rdata_o,

    // main requester
    input  logic                hs_req_i,
    input  logic                hs_we_i,
    input  adam_bus_pkg::addr_t hs_addr_i,
    input  adam_bus_pkg::strb_t hs_be_i,
    input  adam_bus_pkg::data_t hs_wdata_i,
    output logic                hs_gnt_o,
    output logic                hs_rvalid_o,
    output adam_bus_pkg::data_t hs_rdata_o,

    output adam_bus_pkg::addr_t cpu_boot_addr_o,
    output logic                cpu_irq_o
);

    adam_bus_if lp_bus ();
    adam_bus_if hs_bus ();
    adam_bus_if sys_bus ();
    adam_bus_if mem_bus ();
    adam_bus_if cfg_bus ();

    logic mem_rst;
    logic mem_pause;

    assign lp_bus.req   = lp_req_i;
    assign lp_bus.we    = lp_we_i;
    assign lp_bus.addr  = lp_addr_i;
    assign lp_bus.be    = lp_be_i;
    assign lp_bus.wdata = lp_wdata_i;
    assign lp_gnt_o     = lp_bus.gnt;
    assign lp_rvalid_o  = lp_bus.rvalid;
    assign lp_rdata_o   = lp_bus.rdata;

    assign hs_bus.req   = hs_req_i;
    assign hs_bus.we    = hs_we_i;
    assign hs_bus.addr  = hs_addr_i;
    assign hs_bus.be    = hs_be_i;
    assign hs_bus.wdata = hs_wdata_i;
    assign hs_gnt_o     = hs_bus.gnt;
    assign hs_rvalid_o  = hs_bus.rvalid;
    assign hs_rdata_o   = hs_bus.rdata;

    adam_arbiter i_arbiter (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .lp_bus  (lp_bus),
        .hs_bus  (hs_bus),
        .sys_bus (sys_bus)
    );

    adam_decoder i_decoder (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .sys_bus (sys_bus),
        .mem_bus (mem_bus),
        .cfg_bus (cfg_bus)
    );

    adam_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) i_mem (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .bus         (mem_bus),
        .mem_rst_i   (mem_rst),
        .mem_pause_i (mem_pause)
    );

    adam_syscfg #(
        .BOOT_ADDR_RESET (BOOT_ADDR_RESET)
    ) i_syscfg (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .bus             (cfg_bus),
        .mem_rst_o       (mem_rst),
        .mem_pause_o     (mem_pause),
        .cpu_irq_o       (cpu_irq_o),
        .cpu_boot_addr_o (cpu_boot_addr_o)
    );

endmodule

/* tests/adam_tb.sv */
module adam_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int                  MEM_WORDS  = 1024;
    localparam adam_bus_pkg::addr_t BOOT_RESET = 16'h0100;
    localparam adam_bus_pkg::addr_t CFG_CTRL   = 16'h8000;
    localparam int                  N_PAT      = 21;
    localparam int                  N_RAND     = 40;

    logic                clk_i = 1'b0;
    logic                rst_i;
    logic [1:0]          req;
    logic [1:0]          we;
    adam_bus_pkg::addr_t addr [2];
    adam_bus_pkg::strb_t be [2];
    adam_bus_pkg::data_t wdata [2];
    wire  [1:0]          gnt;
    wire  [1:0]          rvalid;
    adam_bus_pkg::data_t lp_rdata;
    adam_bus_pkg::data_t hs_rdata;
    adam_bus_pkg::addr_t boot_addr;
    logic                cpu_irq;

    // reference models of the RAM and the configuration outputs
    adam_bus_pkg::data_t mem_m [MEM_WORDS];
    adam_bus_pkg::addr_t boot_m;
    logic                irq_m;

    logic [31:0] pat [0:7*N_PAT-1];
    logic [31:0] lfsr_q;
    string       cur_test;
    int          errors;
    int          err_mark;
    int          tests_run;
    int          tests_failed;

    adam_mini #(
        .MEM_WORDS       (MEM_WORDS),
        .BOOT_ADDR_RESET (BOOT_RESET)
    ) dut_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .lp_req_i        (req[0]),
        .lp_we_i         (we[0]),
        .lp_addr_i       (addr[0]),
        .lp_be_i         (be[0]),
        .lp_wdata_i      (wdata[0]),
        .lp_gnt_o        (gnt[0]),
        .lp_rvalid_o     (rvalid[0]),
        .lp_rdata_o      (lp_rdata),
        .hs_req_i        (req[1]),
        .hs_we_i         (we[1]),
        .hs_addr_i       (addr[1]),
        .hs_be_i         (be[1]),
        .hs_wdata_i      (wdata[1]),
        .hs_gnt_o        (gnt[1]),
        .hs_rvalid_o     (rvalid[1]),
        .hs_rdata_o      (hs_rdata),
        .cpu_boot_addr_o (boot_addr),
        .cpu_irq_o       (cpu_irq)
    );

    always #10 clk_i = ~clk_i;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // applies the byte merge to the RAM model or the BOOT_ADDR and IRQ rules
    function automatic void model_write(input adam_bus_pkg::addr_t a,
                                        input adam_bus_pkg::strb_t b,
                                        input adam_bus_pkg::data_t d);
        int idx;
        idx = int'(a[14:2]) % MEM_WORDS;
        if (!a[15]) begin
            for (int k = 0; k < 4; k++) begin
                if (b[k]) mem_m[idx][8*k +: 8] = d[8*k +: 8];
            end
        end else if (a[3:2] == 2'd1) begin
            if (b[0]) boot_m[7:0] = d[7:0];
            if (b[1]) boot_m[15:8] = d[15:8];
        end else if (a[3:2] == 2'd2 && b[0]) begin
            irq_m = d[0];
        end
    endfunction

    task automatic check_value(input adam_bus_pkg::data_t exp, input adam_bus_pkg::data_t act);
        assert (act === exp) else begin
            $display("Error %s: expected %h, actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    // one request on port p held until gnt and answered one cycle later
    task automatic bus_transfer(input int p, input logic w, input adam_bus_pkg::addr_t a,
                                input adam_bus_pkg::strb_t b, input adam_bus_pkg::data_t d,
                                output adam_bus_pkg::data_t rd);
        @(posedge clk_i);
        req[p]   <= 1'b1;
        we[p]    <= w;
        addr[p]  <= a;
        be[p]    <= b;
        wdata[p] <= d;
        @(negedge clk_i);
        while (!gnt[p]) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        req[p] <= 1'b0;
        @(negedge clk_i);
        assert (rvalid[p]) else begin
            $display("%s: port %0d got no response in the cycle after its grant", cur_test, p);
            errors++;
        end
        rd = p ? hs_rdata : lp_rdata;
        if (w) model_write(a, b, d);
    endtask

    task automatic replay_patterns(input int tag);
        adam_bus_pkg::data_t rd;
        for (int i = 0; i < N_PAT; i++) begin
            if (pat[7*i+6] == tag) begin
                bus_transfer(pat[7*i], pat[7*i+1][0], pat[7*i+2][15:0], pat[7*i+3][3:0],
                             pat[7*i+4], rd);
                check_value(pat[7*i+5], rd);
                check_value(adam_bus_pkg::data_t'(boot_m), adam_bus_pkg::data_t'(boot_addr));
                check_value({31'b0, irq_m}, {31'b0, cpu_irq});
            end
        end
    endtask

    // full write then a partial write from the other port and a read back
    task automatic random_mem_loop(input int count);
        logic [31:0]         v;
        int                  p;
        adam_bus_pkg::addr_t a;
        adam_bus_pkg::strb_t b;
        adam_bus_pkg::data_t rd;
        for (int i = 0; i < count; i++) begin
            take_bits(1, v);
            p = int'(v[0]);
            // 11 index bits reach past MEM_WORDS, so aliases get hit too
            take_bits(11, v);
            a = {3'b000, v[10:0], 2'b00};
            take_bits(32, v);
            bus_transfer(p, 1'b1, a, 4'hF, v, rd);
            check_value(32'h0, rd);
            take_bits(4, v);
            b = v[3:0];
            take_bits(32, v);
            bus_transfer(1 - p, 1'b1, a, b, v, rd);
            check_value(32'h0, rd);
            bus_transfer(p, 1'b0, a, 4'h0, 32'h0, rd);
            check_value(mem_m[int'(a[14:2]) % MEM_WORDS], rd);
        end
    endtask

    // both ports request memory writes every cycle
    task automatic contend_ports(input int rounds);
        int n [2];
        int prev;
        int want;
        n    = '{0, 0};
        prev = -1;
        want = 0;
        for (int i = 0; i < rounds; i++) begin
            @(posedge clk_i);
            // only the last winner moves on to new fields
            for (int p = 0; p < 2; p++) begin
                req[p]   <= 1'b1;
                we[p]    <= 1'b1;
                addr[p]  <= 16'(16'h0800 + p * 16'h0400 + n[p] * 4);
                be[p]    <= 4'hF;
                wdata[p] <= 32'hA000_0000 + 32'(p * 16'h1000 + n[p]);
            end
            @(negedge clk_i);
            assert (gnt[want] && !gnt[1 - want]) else begin
                $display("%s: grant went to the wrong port in round %0d", cur_test, i);
                errors++;
            end
            assert (rvalid[0] == (prev == 0) && rvalid[1] == (prev == 1)) else begin
                $display("%s: response missing or on the wrong port in round %0d", cur_test, i);
                errors++;
            end
            if (prev >= 0) check_value(32'h0, prev ? hs_rdata : lp_rdata);
            model_write(addr[want], 4'hF, wdata[want]);
            n[want]++;
            prev = want;
            want = 1 - want;
        end
        @(posedge clk_i);
        req <= 2'b00;
        @(negedge clk_i);
        assert (rvalid[prev]) else begin
            $display("%s: last transfer got no response", cur_test);
            errors++;
        end
    endtask

    // memory held by a CTRL bit while hs waits on word 0
    task automatic stall_memory(input adam_bus_pkg::data_t ctrl_val, input int cycles);
        adam_bus_pkg::data_t exp;
        adam_bus_pkg::data_t rd_lp;
        adam_bus_pkg::data_t rd_hs;
        exp = mem_m[0];
        bus_transfer(0, 1'b1, CFG_CTRL, 4'h1, ctrl_val, rd_lp);
        check_value(32'h0, rd_lp);
        // hs wins a turn here, so lp comes first on the next contention
        bus_transfer(1, 1'b0, CFG_CTRL, 4'h0, 32'h0, rd_hs);
        check_value(ctrl_val, rd_hs);
        fork
            begin
                bus_transfer(1, 1'b0, 16'h0000, 4'h0, 32'h0, rd_hs);
                check_value(exp, rd_hs);
            end
            begin
                @(posedge clk_i);
                repeat (cycles) begin
                    @(negedge clk_i);
                    assert (!gnt[1]) else begin
                        $display("%s: hs was granted memory while it is held", cur_test);
                        errors++;
                    end
                end
                bus_transfer(0, 1'b1, CFG_CTRL, 4'h1, 32'h0, rd_lp);
                check_value(32'h0, rd_lp);
            end
        join
    endtask

    function automatic void start_test(input string name);
        cur_test = name;
        err_mark = errors;
    endfunction

    function automatic void end_test();
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, errors - err_mark);
        end
    endfunction

    initial begin
        rst_i  = 1'b1;
        req    = 2'b00;
        we     = 2'b00;
        addr   = '{16'h0, 16'h0};
        be     = '{4'h0, 4'h0};
        wdata  = '{32'h0, 32'h0};
        lfsr_q = 32'h39dc_06c8;
        boot_m = BOOT_RESET;
        irq_m  = 1'b0;
        errors = 0;
        $readmemh("tests/adam_patterns.hex", pat);
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;

        // first after reset, so lp must win the opening round
        start_test("arbitration");
        contend_ports(20);
        end_test();
        start_test("reset_values");
        replay_patterns(1);
        end_test();
        start_test("mem_byte_enables");
        replay_patterns(2);
        random_mem_loop(N_RAND);
        end_test();
        start_test("cfg_outputs");
        replay_patterns(3);
        end_test();
        start_test("mem_pause");
        stall_memory(32'h2, 30);
        end_test();
        start_test("mem_reset");
        stall_memory(32'h1, 30);
        end_test();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat ((N_PAT + N_RAND) * 64 + 2000) @(posedge clk_i);
        $display("timeout in test %s, the run did not finish in time", cur_test);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* adam_mini.f */
src/adam_bus_pkg.sv
src/adam_map_pkg.sv
src/adam_bus_if.sv
src/adam_arbiter.sv
src/adam_decoder.sv
src/adam_mem.sv
src/adam_syscfg.sv
src/adam_mini.sv
tests/adam_tb.sv

/* tests/adam_patterns.hex */
// port we addr be wdata expected_rdata tag
// port 0 is lp and 1 is hs; tag 1 reset values, 2 memory byte enables, 3 configuration
0 0 8000 0 00000000 00000000 1
1 0 8008 0 00000000 00000000 1
0 0 800C 0 00000000 00000000 1
1 0 8004 0 00000000 00000100 1
0 1 0000 F 11223344 00000000 2
1 1 0000 5 AABBCCDD 00000000 2
0 0 0000 0 00000000 11BB33DD 2
1 1 0010 F 00000000 00000000 2
0 1 0010 6 00ABCD00 00000000 2
1 0 0010 0 00000000 00ABCD00 2
1 1 1010 9 EE0000FF 00000000 2
0 0 0010 0 00000000 EEABCDFF 2
1 0 1000 0 00000000 11BB33DD 2
0 1 8004 3 00002468 00000000 3
1 0 8004 0 00000000 00002468 3
0 1 8008 1 00000001 00000000 3
1 0 8008 0 00000000 00000001 3
0 1 8008 1 00000000 00000000 3
0 0 8008 0 00000000 00000000 3
1 1 8004 2 0000AB00 00000000 3
0 0 8004 0 00000000 0000AB68 3
